/* Makefile */
SOURCES := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/VsCurveTestTb
	@out="$$(./obj_dir/VsCurveTestTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

obj_dir/VsCurveTestTb: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module sCurveTestTb -f sim.f

clean:
	rm -rf obj_dir

/* dv/sCurveAsicModel.sv */
`timescale 1ns/1ps

module sCurveAsicModel import sCurvePkg::*; (
  input  logic         Clk,
  input  logic         reset_n,
  input  sCurveConfigT asicConfig,
  input  logic         configLoadStart,
  output logic         configDone,
  input  logic         clkExt,
  output logic [2:0]   triggerB
);

  logic [2:0] loadPipe;
  logic clkExtPrev;
  logic [1:0] firePipe;
  logic fireNow;
  logic trigHold;
  int channel;

  // Channel under test from the Ctest one-hot
  // falls back to the first enabled discriminator
  always_comb begin
    channel = 0;
    if (asicConfig.ctestChannels != '0) begin
      for (int i = ChannelCount - 1; i >= 0; i--) begin
        if (asicConfig.ctestChannels[i]) channel = i;
      end
    end else begin
      for (int i = MaskWidth - 1; i >= 0; i--) begin
        if (asicConfig.discriminatorMask[i]) channel = i / 3;
      end
    end
  end

  // Slow control finishes 3 cycles after the load
  assign configDone = loadPipe[2];
  // Threshold rises 10 DAC steps per channel
  assign fireNow = firePipe[1] && (int'(asicConfig.dac) >= 10 * channel + 100);

  always @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      loadPipe <= '0;
      clkExtPrev <= 1'b0;
      firePipe <= '0;
      trigHold <= 1'b0;
      triggerB <= '1;
    end else begin
      loadPipe <= {loadPipe[1:0], configLoadStart};
      clkExtPrev <= clkExt;
      // Trigger lands 2 cycles after the clkExt edge
      firePipe <= {firePipe[0], clkExt & ~clkExtPrev};
      trigHold <= fireNow;
      // Two-cycle low pulse, pin picked by channel
      if (fireNow || trigHold) begin
        triggerB <= ~(3'd1 << (channel % 3));
      end else begin
        triggerB <= '1;
      end
    end
  end

endmodule

/* dv/sCurveTestTb.sv */
`timescale 1ns/1ps

module sCurveTestTb import sCurvePkg::*; ();

  localparam int ClkExtPeriod = 8;
  // Window length the model's trigger needs after a clkExt edge
  localparam int TriggerLatency = 3;
  // Worst point: config, 20 clkExt events or 5 ticks, back-pressure
  localparam int PointBound = 400;
  localparam int TotalPoints = 5 + 5 + 2 * ChannelCount + 3 + 4;
  localparam int CycleLimit = 2 * TotalPoints * PointBound;

  typedef struct packed {
    logic [WordWidth-1:0] value;
    logic [WordWidth-1:0] tolerance;
  } expWordT;

  typedef struct packed {
    logic [ChannelWidth-1:0] channel;
    logic [DacWidth-1:0] dac;
  } sweepPointT;

  logic Clk;
  logic reset_n;
  logic startLevel;
  sCurveParamT params;
  logic testDone;
  logic dataTransmitDone;
  sCurveConfigT asicConfig;
  logic configLoadStart;
  logic configDone;
  logic forceExtRaz;
  logic clkExt;
  logic [2:0] triggerB;
  logic [WordWidth-1:0] dataOut;
  logic dataOutValid;
  logic usbFifoFull;

  // Scoreboard state
  expWordT wordQ[$];
  sweepPointT pointQ[$];
  int cfgIdx;
  int wordsSeen;
  int mismatchCount;
  int failCount;
  int cycleCount;
  int clkPhase;
  integer seed;
  logic bpEnable;
  logic prevUsbFull;
  // Between a configuration load and its done pulse
  logic razWindow;

  sCurveTestTop i_dut (
    .Clk              (Clk),
    .reset_n          (reset_n),
    .startLevel       (startLevel),
    .params           (params),
    .testDone         (testDone),
    .dataTransmitDone (dataTransmitDone),
    .asicConfig       (asicConfig),
    .configLoadStart  (configLoadStart),
    .configDone       (configDone),
    .forceExtRaz      (forceExtRaz),
    .clkExt           (clkExt),
    .triggerB         (triggerB),
    .dataOut          (dataOut),
    .dataOutValid     (dataOutValid),
    .usbFifoFull      (usbFifoFull)
  );

  sCurveAsicModel asicModel (
    .Clk             (Clk),
    .reset_n         (reset_n),
    .asicConfig      (asicConfig),
    .configLoadStart (configLoadStart),
    .configDone      (configDone),
    .clkExt          (clkExt),
    .triggerB        (triggerB)
  );

  initial begin
    Clk = 1'b0;
    forever #50 Clk = ~Clk;
  end

  //////////////////////////////
  // Pin stimulus
  //////////////////////////////
  // External test clock, 8 Clk cycles
  always @(negedge Clk) begin
    clkPhase = (clkPhase + 1) % ClkExtPeriod;
    clkExt = (clkPhase < ClkExtPeriod / 2);
  end

  // Random USB back-pressure
  always @(negedge Clk) begin
    logic [31:0] rnd;
    if (bpEnable) begin
      rnd = $random(seed);
      usbFifoFull = rnd[0];
    end else begin
      usbFifoFull = 1'b0;
    end
  end

  //////////////////////////////
  // Checkers
  //////////////////////////////
  function automatic bit aboveThreshold(input int ch, input int dac);
    return dac >= 10 * ch + 100;
  endfunction

  task automatic checkWord(input logic [WordWidth-1:0] word);
    expWordT exp;
    int diff;
    wordsSeen++;
    assert (wordQ.size() > 0) else begin
      failCount++;
      $display("unexpected output word %h at %0t, none was left to expect", word, $time);
    end
    if (wordQ.size() > 0) begin
      exp = wordQ.pop_front();
      diff = int'(word) - int'(exp.value);
      if (diff < 0) diff = -diff;
      assert (diff <= int'(exp.tolerance)) else begin
        mismatchCount++;
        $display("mismatch at %0t: word %0d is %h, expected %h within %0d", $time,
                 wordsSeen, word, exp.value, exp.tolerance);
      end
    end
  endtask

  task automatic checkConfig();
    sweepPointT pt;
    logic [ChannelCount-1:0] expCtest;
    logic [MaskWidth-1:0] expMask;
    assert (cfgIdx < pointQ.size()) else begin
      failCount++;
      $display("configuration load at %0t past the end of the sweep", $time);
    end
    if (cfgIdx < pointQ.size()) begin
      pt = pointQ[cfgIdx];
      expCtest = '0;
      expMask = '0;
      for (int i = 0; i < ChannelCount; i++) begin
        expCtest[i] = params.ctestOrInput && (i == int'(pt.channel));
        for (int b = 0; b < 3; b++) begin
          expMask[3 * i + b] = params.unmaskAll || (i == int'(pt.channel));
        end
      end
      assert (asicConfig.dac == pt.dac) else begin
        mismatchCount++;
        $display("mismatch at %0t: dac %0d, expected %0d", $time, asicConfig.dac, pt.dac);
      end
      assert (asicConfig.ctestChannels == expCtest) else begin
        mismatchCount++;
        $display("mismatch at %0t: ctestChannels %h for channel %0d", $time,
                 asicConfig.ctestChannels, pt.channel);
      end
      assert (asicConfig.discriminatorMask == expMask) else begin
        mismatchCount++;
        $display("mismatch at %0t: discriminator mask wrong for channel %0d", $time,
                 pt.channel);
      end
      cfgIdx++;
    end
  endtask

  // Registered outputs read before the edge updates them
  always @(posedge Clk) begin
    if (reset_n) begin
      if (dataOutValid) checkWord(dataOut);
      if (configLoadStart) checkConfig();
      assert (!(dataOutValid && prevUsbFull)) else begin
        failCount++;
        $display("a word left at %0t although the USB FIFO was full", $time);
      end
      // High from the load through the done pulse, low otherwise
      assert (forceExtRaz == (configLoadStart || razWindow)) else begin
        mismatchCount++;
        $display("mismatch at %0t: forceExtRaz %b, expected %b", $time, forceExtRaz,
                 configLoadStart || razWindow);
      end
      if (configLoadStart) razWindow = 1'b1;
      if (configDone) razWindow = 1'b0;
    end else begin
      razWindow = 1'b0;
    end
    prevUsbFull = usbFifoFull;
  end

  // Run limit
  always @(posedge Clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("timeout after %0d cycles, the test never completed", cycleCount);
      $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Sweep driver
  //////////////////////////////
  task automatic buildExpectation(input sCurveParamT p);
    int firstCh;
    int lastCh;
    int dac;
    bit above;
    sweepPointT pt;
    expWordT w;
    wordQ.delete();
    pointQ.delete();
    cfgIdx = 0;
    wordsSeen = 0;
    firstCh = p.singleChannel ? int'(p.testChannel) : 0;
    lastCh = p.singleChannel ? int'(p.testChannel) : ChannelCount - 1;
    // Channel outer, DAC inner
    for (int ch = firstCh; ch <= lastCh; ch++) begin
      dac = int'(p.startDac);
      while (dac <= int'(p.endDac)) begin
        pt.channel = ChannelWidth'(ch);
        pt.dac = DacWidth'(dac);
        pointQ.push_back(pt);
        w.value = {pt.channel, pt.dac};
        w.tolerance = '0;
        wordQ.push_back(w);
        above = aboveThreshold(ch, dac);
        if (p.efficiencyMode) begin
          // One hit per clkExt event when the window reaches the trigger
          w.value = (above && int'(p.triggerDelay) >= TriggerLatency) ? p.cptMax : '0;
        end else begin
          // One trigger per clkExt period over the tick window
          w.value = above ? WordWidth'(int'(p.counterMax) * TickDivider / ClkExtPeriod) : '0;
          w.tolerance = above ? 16'd1 : 16'd0;
        end
        wordQ.push_back(w);
        if (p.dacStep == '0) break;
        dac += int'(p.dacStep);
      end
    end
  endtask

  task automatic runSweep(input sCurveParamT p, input string name);
    int expWords;
    buildExpectation(p);
    expWords = wordQ.size();
    @(negedge Clk);
    params = p;
    repeat (2) @(negedge Clk);
    startLevel = 1'b1;
    while (!testDone) @(negedge Clk);
    assert (wordQ.size() == 0) else begin
      failCount++;
      $display("%s ended with %0d words never received", name, wordQ.size());
    end
    assert (wordsSeen == expWords) else begin
      mismatchCount++;
      $display("mismatch at %0t: %0d words, expected %0d", $time, wordsSeen, expWords);
    end
    assert (cfgIdx == pointQ.size()) else begin
      failCount++;
      $display("%s loaded %0d configurations for %0d points", name, cfgIdx, pointQ.size());
    end
    startLevel = 1'b0;
    repeat (3) @(negedge Clk);
    assert (testDone) else begin
      failCount++;
      $display("testDone fell before dataTransmitDone in %s", name);
    end
    dataTransmitDone = 1'b1;
    @(negedge Clk);
    dataTransmitDone = 1'b0;
    @(negedge Clk);
    assert (!testDone) else begin
      failCount++;
      $display("testDone stayed high after dataTransmitDone in %s", name);
    end
    $display("%s finished with %0d words", name, wordsSeen);
  endtask

  function automatic sCurveParamT channelFiveParams();
    sCurveParamT p;
    p = '0;
    p.efficiencyMode = 1'b1;
    p.singleChannel = 1'b1;
    p.testChannel = 6'd5;
    p.ctestOrInput = 1'b1;
    p.startDac = 10'd100;
    p.endDac = 10'd200;
    p.dacStep = 10'd25;
    p.cptMax = 16'd20;
    p.triggerDelay = 4'd4;
    return p;
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic singleChannelTrigger();
    runSweep(channelFiveParams(), "single channel trigger efficiency");
  endtask

  task automatic delayWindow();
    sCurveParamT p;
    p = channelFiveParams();
    // Window closes before the trigger arrives
    p.triggerDelay = 4'd1;
    runSweep(p, "short delay window");
  endtask

  task automatic fullChannelSweep();
    sCurveParamT p;
    p = channelFiveParams();
    p.singleChannel = 1'b0;
    p.ctestOrInput = 1'b0;
    p.endDac = 10'd700;
    p.dacStep = 10'd600;
    p.cptMax = 16'd4;
    runSweep(p, "64 channel sweep");
    assert (wordsSeen == ChannelCount * 2 * 2) else begin
      mismatchCount++;
      $display("mismatch at %0t: sweep gave %0d words", $time, wordsSeen);
    end
  endtask

  task automatic countEfficiency();
    sCurveParamT p;
    p = channelFiveParams();
    p.efficiencyMode = 1'b0;
    p.unmaskAll = 1'b1;
    p.dacStep = 10'd50;
    p.counterMax = 16'd4;
    runSweep(p, "count efficiency");
  endtask

  task automatic backPressure();
    sCurveParamT p;
    p = channelFiveParams();
    p.testChannel = 6'd37;
    p.startDac = 10'd300;
    p.endDac = 10'd600;
    p.dacStep = 10'd100;
    p.cptMax = 16'd6;
    p.triggerDelay = 4'd5;
    bpEnable = 1'b1;
    runSweep(p, "USB back-pressure");
    bpEnable = 1'b0;
  endtask

  initial begin
    reset_n = 1'b0;
    startLevel = 1'b0;
    params = '0;
    dataTransmitDone = 1'b0;
    usbFifoFull = 1'b0;
    clkExt = 1'b0;
    clkPhase = 0;
    bpEnable = 1'b0;
    prevUsbFull = 1'b0;
    razWindow = 1'b0;
    seed = 32'hb6ec55d8;
    cfgIdx = 0;
    wordsSeen = 0;
    mismatchCount = 0;
    failCount = 0;
    cycleCount = 0;
    // Two rising edges in reset, release on the falling edge
    repeat (2) @(posedge Clk);
    @(negedge Clk);
    assert (!configLoadStart && !dataOutValid && !testDone && !forceExtRaz) else begin
      failCount++;
      $display("strobes or levels were not low during reset");
    end
    reset_n = 1'b1;
    singleChannelTrigger();
    delayWindow();
    fullChannelSweep();
    countEfficiency();
    backPressure();
    repeat (4) @(negedge Clk);
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    if (mismatchCount == 0 && failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/sCurvePkg.sv
verilog/sCurveTimebase.sv
verilog/sCurvePointCounter.sv
verilog/sCurveDataFifo.sv
verilog/sCurveSweepControl.sv
verilog/sCurveTestTop.sv
dv/sCurveAsicModel.sv
dv/sCurveTestTb.sv

/* verilog/sCurveDataFifo.sv */
`timescale 1ns/1ps

module sCurveDataFifo import sCurvePkg::*; (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 flush,
  input  logic [WordWidth-1:0] wrData,
  input  logic                 wrEn,
  input  logic                 rdEn,
  output logic [WordWidth-1:0] rdData,
  output logic                 full,
  output logic                 empty
);

  logic [WordWidth-1:0] mem [FifoDepth];
  // Extra wrap bit tells full from empty
  logic [FifoAddrWidth:0] wrPtr;
  logic [FifoAddrWidth:0] rdPtr;
  logic doWrite;
  logic doRead;

  assign empty = (wrPtr == rdPtr);
  assign full = (wrPtr[FifoAddrWidth] != rdPtr[FifoAddrWidth]) &&
                (wrPtr[FifoAddrWidth-1:0] == rdPtr[FifoAddrWidth-1:0]);
  assign doWrite = wrEn && !full;
  assign doRead = rdEn && !empty;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else if (flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doWrite) wrPtr <= wrPtr + 1'b1;
      if (doRead) rdPtr <= rdPtr + 1'b1;
    end
  end

  // Storage and registered read port
  always_ff @(posedge Clk) begin
    if (doWrite) begin
      mem[wrPtr[FifoAddrWidth-1:0]] <= wrData;
    end
    if (doRead) begin
      rdData <= mem[rdPtr[FifoAddrWidth-1:0]];
    end
  end

endmodule

/* verilog/sCurvePkg.sv */
package sCurvePkg;

  ////////////////////////////////
  // ASIC geometry and widths
  ////////////////////////////////
  localparam int ChannelCount = 64;
  localparam int ChannelWidth = $clog2(ChannelCount);
  localparam int DacWidth = 10;
  // Three discriminators per channel
  localparam int MaskWidth = 3 * ChannelCount;
  localparam int WordWidth = 16;

  // Clk cycles per slow tick, short for simulation
  localparam int TickDivider = 50;
  localparam int TickWidth = $clog2(TickDivider);

  // Result buffer
  localparam int FifoDepth = 16;
  localparam int FifoAddrWidth = $clog2(FifoDepth);

  ////////////////////////////////
  // Host test parameters
  ////////////////////////////////
  typedef struct packed {
    logic efficiencyMode;              // High for trigger efficiency
    logic singleChannel;
    logic [ChannelWidth-1:0] testChannel;
    logic ctestOrInput;                // Charge injection via Ctest
    logic unmaskAll;
    logic [DacWidth-1:0] startDac;
    logic [DacWidth-1:0] endDac;
    logic [DacWidth-1:0] dacStep;
    logic [15:0] cptMax;               // External clock events per point
    logic [15:0] counterMax;           // Slow ticks per point
    logic [3:0] triggerDelay;
  } sCurveParamT;

  // Slow-control outputs toward the ASIC
  typedef struct packed {
    logic [ChannelCount-1:0] ctestChannels;
    logic [DacWidth-1:0] dac;
    logic [MaskWidth-1:0] discriminatorMask;
  } sCurveConfigT;

  ////////////////////////////////
  // FSM states
  ////////////////////////////////
  typedef enum logic [2:0] {
    SweepIdle,
    SweepConfigure,
    SweepWaitConfig,
    SweepMeasure,
    SweepDrain,
    SweepDone
  } sweepStateT;

  typedef enum logic [1:0] {
    CountIdle,
    CountRun,
    CountDelay,
    CountFinish
  } counterStateT;

endpackage

/* verilog/sCurvePointCounter.sv */
`timescale 1ns/1ps

module sCurvePointCounter import sCurvePkg::*; (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  sCurveParamT          params,
  input  logic                 measureStart,
  input  logic                 tick,
  input  logic                 clkExtRise,
  input  logic                 trigFall,
  output logic [WordWidth-1:0] countData,
  output logic                 wrEn,
  output logic                 pointDone
);

  counterStateT state;
  logic [15:0] eventCount;
  logic [15:0] tickCount;
  logic [WordWidth-1:0] hitCount;
  logic [3:0] delayCount;
  // Count window opens on the first tick after start
  logic windowOpen;
  logic hitSaturated;

  assign hitSaturated = &hitCount;
  assign countData = hitCount;
  // Result write and done share the finish cycle
  assign wrEn = (state == CountFinish);
  assign pointDone = (state == CountFinish);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= CountIdle;
      eventCount <= '0;
      tickCount <= '0;
      hitCount <= '0;
      delayCount <= '0;
      windowOpen <= 1'b0;
    end else begin
      case (state)
        CountIdle: begin
          if (measureStart) begin
            eventCount <= '0;
            tickCount <= '0;
            hitCount <= '0;
            windowOpen <= 1'b0;
            state <= CountRun;
          end
        end
        CountRun: begin
          if (params.efficiencyMode) begin
            // Each external clock edge opens a delay window
            if (clkExtRise) begin
              eventCount <= eventCount + 1'b1;
              delayCount <= 4'd1;
              state <= CountDelay;
            end
          end else if (!windowOpen) begin
            if (tick) begin
              windowOpen <= 1'b1;
            end
          end else begin
            // Count mode, every trigger edge in the window
            if (trigFall && !hitSaturated) begin
              hitCount <= hitCount + 1'b1;
            end
            if (tick) begin
              tickCount <= tickCount + 1'b1;
              if ((tickCount + 17'd1) >= params.counterMax) begin
                state <= CountFinish;
              end
            end
          end
        end
        CountDelay: begin
          if (trigFall && !hitSaturated) begin
            hitCount <= hitCount + 1'b1;
          end
          // One hit per event closes the window early
          if (trigFall || delayCount >= params.triggerDelay) begin
            state <= (eventCount >= params.cptMax) ? CountFinish : CountRun;
          end else begin
            delayCount <= delayCount + 1'b1;
          end
        end
        CountFinish: state <= CountIdle;
        default: state <= CountIdle;
      endcase
    end
  end

endmodule

/* verilog/sCurveSweepControl.sv */
`timescale 1ns/1ps

module sCurveSweepControl import sCurvePkg::*; (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  sCurveParamT          params,
  input  logic                 startPulse,
  output sCurveConfigT         asicConfig,
  output logic                 configLoadStart,
  input  logic                 configDone,
  output logic                 forceExtRaz,
  output logic                 measureStart,
  input  logic                 pointDone,
  input  logic                 fifoEmpty,
  input  logic                 fifoFull,
  input  logic [WordWidth-1:0] fifoRdData,
  output logic                 fifoRdEn,
  output logic                 flush,
  output logic [WordWidth-1:0] dataOut,
  output logic                 dataOutValid,
  input  logic                 usbFifoFull,
  output logic                 testDone,
  input  logic                 dataTransmitDone
);

  typedef struct packed {
    logic last;
    logic [ChannelWidth-1:0] channel;
    logic [DacWidth-1:0] dac;
  } sweepPointT;

  sweepStateT state;
  logic [ChannelWidth-1:0] channel;
  logic [DacWidth-1:0] dac;
  logic [ChannelWidth-1:0] firstChannel;
  logic pointEnded;
  sweepPointT sweepNext;
  // Output side replays the same sweep order for headers
  logic [ChannelWidth-1:0] outChannel;
  logic [DacWidth-1:0] outDac;
  sweepPointT outNext;
  logic outBusy;
  logic rdPending;
  logic countReady;
  logic outFinished;
  logic emitCount;
  logic [WordWidth-1:0] countWord;
  logic [WordWidth-1:0] headerWord;

  // DAC loop inner, channel loop outer
  function automatic sweepPointT nextPoint(input logic [ChannelWidth-1:0] chan,
                                           input logic [DacWidth-1:0] value);
    logic [DacWidth:0] dacSum;
    sweepPointT result;
    dacSum = value + params.dacStep;
    result.last = 1'b0;
    result.channel = chan;
    result.dac = dacSum[DacWidth-1:0];
    // Zero step ends the DAC loop at once
    if (params.dacStep == '0 || dacSum > params.endDac) begin
      result.dac = params.startDac;
      if (params.singleChannel || chan == ChannelWidth'(ChannelCount - 1)) begin
        result.last = 1'b1;
      end else begin
        result.channel = chan + 1'b1;
      end
    end
    return result;
  endfunction

  assign firstChannel = params.singleChannel ? params.testChannel : '0;
  assign sweepNext = nextPoint(channel, dac);
  assign outNext = nextPoint(outChannel, outDac);

  ////////////////////////////////
  // Slow-control outputs
  ////////////////////////////////
  always_comb begin
    asicConfig.dac = dac;
    asicConfig.ctestChannels = params.ctestOrInput ? (ChannelCount'(1) << channel) : '0;
    // Mask bit high enables a discriminator
    asicConfig.discriminatorMask = params.unmaskAll ? '1 :
                                   (MaskWidth'(3'b111) << (3 * channel));
  end

  assign configLoadStart = (state == SweepConfigure);
  assign forceExtRaz = (state == SweepConfigure) || (state == SweepWaitConfig);
  assign testDone = (state == SweepDone);
  assign flush = (state == SweepDone);

  ////////////////////////////////
  // Sweep FSM
  ////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= SweepIdle;
      channel <= '0;
      dac <= '0;
      pointEnded <= 1'b0;
      measureStart <= 1'b0;
    end else begin
      measureStart <= 1'b0;
      case (state)
        SweepIdle: begin
          if (startPulse) begin
            channel <= firstChannel;
            dac <= params.startDac;
            state <= SweepConfigure;
          end
        end
        SweepConfigure: state <= SweepWaitConfig;
        SweepWaitConfig: begin
          if (configDone) begin
            measureStart <= 1'b1;
            state <= SweepMeasure;
          end
        end
        SweepMeasure: begin
          if (pointDone) pointEnded <= 1'b1;
          // Next point only once the FIFO has room
          if (pointEnded && !fifoFull) begin
            pointEnded <= 1'b0;
            if (sweepNext.last) begin
              state <= SweepDrain;
            end else begin
              channel <= sweepNext.channel;
              dac <= sweepNext.dac;
              state <= SweepConfigure;
            end
          end
        end
        SweepDrain: if (outFinished) state <= SweepDone;
        SweepDone: if (dataTransmitDone) state <= SweepIdle;
        default: state <= SweepIdle;
      endcase
    end
  end

  ////////////////////////////////
  // Output word engine
  ////////////////////////////////
  assign headerWord = {outChannel, outDac};
  // Header goes out with the FIFO read, count follows
  assign fifoRdEn = !fifoEmpty && !outBusy && !usbFifoFull;
  assign emitCount = countReady && !usbFifoFull;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      outChannel <= '0;
      outDac <= '0;
      outBusy <= 1'b0;
      rdPending <= 1'b0;
      countReady <= 1'b0;
      outFinished <= 1'b0;
      dataOutValid <= 1'b0;
    end else begin
      rdPending <= fifoRdEn;
      dataOutValid <= fifoRdEn || emitCount;
      if (startPulse && state == SweepIdle) begin
        outChannel <= firstChannel;
        outDac <= params.startDac;
        outFinished <= 1'b0;
      end
      if (fifoRdEn) outBusy <= 1'b1;
      if (rdPending) countReady <= 1'b1;
      if (emitCount) begin
        countReady <= 1'b0;
        outBusy <= 1'b0;
        outChannel <= outNext.channel;
        outDac <= outNext.dac;
        if (outNext.last) outFinished <= 1'b1;
      end
    end
  end

  // Word payloads
  always_ff @(posedge Clk) begin
    if (rdPending) countWord <= fifoRdData;
    if (fifoRdEn) begin
      dataOut <= headerWord;
    end else if (emitCount) begin
      dataOut <= countWord;
    end
  end

endmodule

/* verilog/sCurveTestTop.sv */
`timescale 1ns/1ps

module sCurveTestTop import sCurvePkg::*; (
  input  logic                 Clk,
  input  logic                 reset_n,
  // Host
  input  logic                 startLevel,
  input  sCurveParamT          params,
  output logic                 testDone,
  input  logic                 dataTransmitDone,
  // ASIC slow control and pins
  output sCurveConfigT         asicConfig,
  output logic                 configLoadStart,
  input  logic                 configDone,
  output logic                 forceExtRaz,
  input  logic                 clkExt,
  input  logic [2:0]           triggerB,
  // USB data FIFO
  output logic [WordWidth-1:0] dataOut,
  output logic                 dataOutValid,
  input  logic                 usbFifoFull
);

  logic startPulse;
  logic tick;
  logic clkExtRise;
  logic trigFall;
  logic measureStart;
  logic pointDone;
  logic [WordWidth-1:0] countData;
  logic wrEn;
  logic fifoRdEn;
  logic [WordWidth-1:0] fifoRdData;
  logic fifoFull;
  logic fifoEmpty;
  logic flush;

  ////////////////////////////////
  // Pin sampling and slow tick
  ////////////////////////////////
  sCurveTimebase timebase (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .startLevel     (startLevel),
    .efficiencyMode (params.efficiencyMode),
    .clkExt         (clkExt),
    .triggerB       (triggerB),
    .startPulse     (startPulse),
    .tick           (tick),
    .clkExtRise     (clkExtRise),
    .trigFall       (trigFall)
  );

  // Channel and DAC sweep, output formatting
  sCurveSweepControl sweepControl (
    .Clk              (Clk),
    .reset_n          (reset_n),
    .params           (params),
    .startPulse       (startPulse),
    .asicConfig       (asicConfig),
    .configLoadStart  (configLoadStart),
    .configDone       (configDone),
    .forceExtRaz      (forceExtRaz),
    .measureStart     (measureStart),
    .pointDone        (pointDone),
    .fifoEmpty        (fifoEmpty),
    .fifoFull         (fifoFull),
    .fifoRdData       (fifoRdData),
    .fifoRdEn         (fifoRdEn),
    .flush            (flush),
    .dataOut          (dataOut),
    .dataOutValid     (dataOutValid),
    .usbFifoFull      (usbFifoFull),
    .testDone         (testDone),
    .dataTransmitDone (dataTransmitDone)
  );

  // One point at a time
  sCurvePointCounter pointCounter (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .params       (params),
    .measureStart (measureStart),
    .tick         (tick),
    .clkExtRise   (clkExtRise),
    .trigFall     (trigFall),
    .countData    (countData),
    .wrEn         (wrEn),
    .pointDone    (pointDone)
  );

  // Counts waiting for the USB side
  sCurveDataFifo dataFifo (
    .Clk     (Clk),
    .reset_n (reset_n),
    .flush   (flush),
    .wrData  (countData),
    .wrEn    (wrEn),
    .rdEn    (fifoRdEn),
    .rdData  (fifoRdData),
    .full    (fifoFull),
    .empty   (fifoEmpty)
  );

endmodule

/* verilog/sCurveTimebase.sv */
`timescale 1ns/1ps

module sCurveTimebase import sCurvePkg::*; (
  input  logic       Clk,
  input  logic       reset_n,
  input  logic       startLevel,
  input  logic       efficiencyMode,
  input  logic       clkExt,
  input  logic [2:0] triggerB,
  output logic       startPulse,
  output logic       tick,
  output logic       clkExtRise,
  output logic       trigFall
);

  logic [1:0] startSync;
  logic [TickWidth-1:0] tickCount;
  // Two sync stages plus one history stage
  logic [2:0] clkExtPipe;
  logic [2:0] trigMeta;
  logic [2:0] trigSync;
  logic trigActive;
  logic trigActivePrev;

  ////////////////////////////////
  // Start edge and slow tick
  ////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      startSync <= '0;
      startPulse <= 1'b0;
      tickCount <= '0;
      tick <= 1'b0;
    end else begin
      startSync <= {startSync[0], startLevel};
      // Registered so the pulse lands two cycles after the level
      startPulse <= startSync[0] & ~startSync[1];
      // Divider parked in trigger mode
      if (efficiencyMode) begin
        tickCount <= '0;
        tick <= 1'b0;
      end else if (tickCount == TickWidth'(TickDivider - 1)) begin
        tickCount <= '0;
        tick <= 1'b1;
      end else begin
        tickCount <= tickCount + 1'b1;
        tick <= 1'b0;
      end
    end
  end

  ////////////////////////////////
  // Pin synchronizers
  ////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      clkExtPipe <= '0;
      // Triggers idle high
      trigMeta <= '1;
      trigSync <= '1;
      trigActivePrev <= 1'b0;
    end else begin
      clkExtPipe <= {clkExtPipe[1:0], clkExt};
      trigMeta <= triggerB;
      trigSync <= trigMeta;
      trigActivePrev <= trigActive;
    end
  end

  // Any of the active-low triggers asserted
  assign trigActive = ~&trigSync;
  assign trigFall = trigActive & ~trigActivePrev;
  assign clkExtRise = clkExtPipe[1] & ~clkExtPipe[2];

endmodule
